/* hdl/ahb_mmio_params.svh */
// AHB-Lite MMIO subsystem build parameters
// Bus widths, fixed PMA region map and UART credit depth

`ifndef AHB_MMIO_PARAMS_SVH
`define AHB_MMIO_PARAMS_SVH

// Bus widths
`define AHB_AW 32
`define AHB_DW 32

//////////////////////////////////////////////////////////////////////
// Region map
//////////////////////////////////////////////////////////////////////

// RAM, TOR range from RAM_BASE up to RAM_BASE + 4*RAM_WORDS
`define RAM_BASE 32'h8000_0000
`define RAM_WORDS 1024
`define RAM_AW ($clog2(`RAM_WORDS))

// Tohost, 16-byte NAPOT block
`define TOHOST_BASE 32'h8000_1000
`define TOHOST_BYTES 16

// UART transmit, single NA4 word
`define UART_TX_ADDR 32'h8000_1080

// Credits held by the UART sender after reset
`define UART_CREDITS 4

`endif

/* hdl/ahb_mmio_pkg.sv */
// AHB-Lite MMIO subsystem types
// Transfer type, transfer size, controller states and target select

package ahb_mmio_pkg;

  // HTRANS encodings
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // HSIZE encodings, only up to one bus word
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_t;

  // Bus controller data phase states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_DATA,
    ST_WAIT,
    ST_ERR1,
    ST_ERR2
  } ctrl_state_t;

  // Decoded target of an address phase
  typedef enum logic [1:0] {
    TGT_NONE   = 2'b00,
    TGT_RAM    = 2'b01,
    TGT_TOHOST = 2'b10,
    TGT_UART   = 2'b11
  } target_t;

endpackage

/* hdl/pma_checker.sv */
// Physical memory attribute check
// Decodes an address phase against the fixed region map (RAM as TOR,
// tohost as NAPOT, UART as NA4), then applies read/write permission
// and natural alignment of the transfer size

`timescale 1ns/10ps

`include "ahb_mmio_params.svh"

module pma_checker import ahb_mmio_pkg::*; (
  input  logic [`AHB_AW-1:0] haddr_i,
  input  logic [2:0]         hsize_i,
  input  logic               hwrite_i,
  output target_t            tgt_o,
  output logic               allowed_o
);

  // Region bounds
  localparam logic [`AHB_AW-1:0] RAM_LO  = `RAM_BASE;
  localparam logic [`AHB_AW-1:0] RAM_HI  = `RAM_BASE + (`RAM_WORDS * 4);
  localparam logic [`AHB_AW-1:0] TOHOST  = `TOHOST_BASE;
  localparam logic [`AHB_AW-1:0] UART_TX = `UART_TX_ADDR;

  // Permissions as {read, write}
  localparam logic [1:0] RAM_PERM    = 2'b11;
  localparam logic [1:0] TOHOST_PERM = 2'b11;
  localparam logic [1:0] UART_PERM   = 2'b01;

  logic       in_ram;
  logic       in_tohost;
  logic       in_uart;
  logic [1:0] perm;
  logic       aligned;

  // TOR, upper bound exclusive
  assign in_ram = (haddr_i >= RAM_LO) && (haddr_i < RAM_HI);

  // NAPOT, ignore offset bits inside the block
  assign in_tohost = ((haddr_i ^ TOHOST) >> $clog2(`TOHOST_BYTES)) == '0;

  // NA4 word match
  assign in_uart = haddr_i[`AHB_AW-1:2] == UART_TX[`AHB_AW-1:2];

  // First match wins
  always_comb begin
    tgt_o = TGT_NONE;
    perm  = 2'b00;
    if (in_ram) begin
      tgt_o = TGT_RAM;
      perm  = RAM_PERM;
    end else if (in_tohost) begin
      tgt_o = TGT_TOHOST;
      perm  = TOHOST_PERM;
    end else if (in_uart) begin
      tgt_o = TGT_UART;
      perm  = UART_PERM;
    end
  end

  // Natural alignment, wider than a word is illegal
  always_comb begin
    case (hsize_t'(hsize_i))
      BYTE:    aligned = 1'b1;
      HALF:    aligned = !haddr_i[0];
      WORD:    aligned = haddr_i[1:0] == 2'b00;
      default: aligned = 1'b0;
    endcase
  end

  assign allowed_o = (tgt_o != TGT_NONE) && aligned && (hwrite_i ? perm[0] : perm[1]);

endmodule

/* hdl/ahb_sram.sv */
// Single-port synchronous RAM
// RAM_WORDS bus words with per-byte write enables. The read is
// registered, so data read in an address phase is valid in the
// following data phase.

`timescale 1ns/10ps

`include "ahb_mmio_params.svh"

module ahb_sram (
  input  logic                 HCLK,
  input  logic                 we_i,
  input  logic                 re_i,
  input  logic [3:0]           be_i,
  input  logic [`RAM_AW-1:0]   addr_i,
  input  logic [`AHB_DW-1:0]   wdata_i,
  output logic [`AHB_DW-1:0]   rdata_o
);

  // Storage array
  logic [`AHB_DW-1:0] mem [`RAM_WORDS];

  // Byte-lane write
  always_ff @(posedge HCLK) begin
    if (we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (be_i[b]) begin
          mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Read register holds its value between reads
  always_ff @(posedge HCLK) begin
    if (re_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

/* hdl/host_mmio.sv */
// Host MMIO registers
// Tohost result register and UART transmit register. Bytes leave on
// uart_data_o with a one-cycle uart_valid_o, each spending one credit;
// the consumer returns credits by pulsing uart_credit_i.

`timescale 1ns/10ps

`include "ahb_mmio_params.svh"

module host_mmio import ahb_mmio_pkg::*; (
  input  logic                 HCLK,
  input  logic                 reset_i,
  input  logic                 we_i,
  input  target_t              sel_i,
  input  logic [`AHB_DW-1:0]   wdata_i,
  input  logic                 uart_credit_i,
  output logic [`AHB_DW-1:0]   rdata_o,
  output logic [`AHB_DW-1:0]   tohost_o,
  output logic                 uart_ready_o,
  output logic [7:0]           uart_data_o,
  output logic                 uart_valid_o
);

  localparam int CW = $clog2(`UART_CREDITS + 1);

  logic [CW-1:0] credits;
  logic          uart_send;

  //////////////////////////////////////////////////////////////////////
  // Tohost
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      tohost_o <= '0;
    end else if (we_i && (sel_i == TGT_TOHOST)) begin
      tohost_o <= wdata_i;
    end
  end

  // Only tohost is readable
  assign rdata_o = tohost_o;

  //////////////////////////////////////////////////////////////////////
  // UART transmit
  //////////////////////////////////////////////////////////////////////

  // Never send without a credit
  assign uart_send    = we_i && (sel_i == TGT_UART) && uart_ready_o;
  assign uart_valid_o = uart_send;
  assign uart_data_o  = wdata_i[7:0];
  assign uart_ready_o = credits != '0;

  // Spend on send, refill on credit pulse, both at once cancel
  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      credits <= CW'(`UART_CREDITS);
    end else begin
      case ({uart_send, uart_credit_i})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

/* hdl/ahb_slave_ctrl.sv */
// AHB-Lite slave bus controller
// Registers accepted address phases, sequences data phases, UART wait
// states and the two-cycle ERROR response, and steers RAM and MMIO
// accesses. RAM writes land in the data phase or, when a read address
// phase holds the RAM port, in a one-entry buffer with read forwarding.

`timescale 1ns/10ps

`include "ahb_mmio_params.svh"

module ahb_slave_ctrl import ahb_mmio_pkg::*; (
  input  logic                   HCLK,
  input  logic                   reset_i,
  input  logic                   hsel_i,
  input  logic [1:0]             htrans_i,
  input  logic                   hwrite_i,
  input  logic [2:0]             hsize_i,
  input  logic [`AHB_AW-1:0]     haddr_i,
  input  logic [`AHB_DW-1:0]     hwdata_i,
  input  target_t                tgt_i,
  input  logic                   allowed_i,
  input  logic                   uart_ready_i,
  input  logic [`AHB_DW-1:0]     ram_rdata_i,
  input  logic [`AHB_DW-1:0]     mmio_rdata_i,
  output logic [`AHB_DW-1:0]     hrdata_o,
  output logic                   hreadyout_o,
  output logic                   hresp_o,
  output logic                   ram_we_o,
  output logic                   ram_re_o,
  output logic [3:0]             ram_be_o,
  output logic [`RAM_AW-1:0]     ram_addr_o,
  output logic [`AHB_DW-1:0]     ram_wdata_o,
  output logic                   mmio_we_o,
  output target_t                mmio_sel_o,
  output logic [`AHB_DW-1:0]     mmio_wdata_o
);

  ctrl_state_t            state;
  ctrl_state_t            state_nxt;
  htrans_t                htrans;
  logic                   addr_phase;
  logic                   rd_ram;
  logic                   wr_dphase;
  logic                   buf_commit;
  logic [3:0]             be_a;

  // Registered address phase
  target_t                tgt_q;
  logic                   write_q;
  logic [3:0]             be_q;
  logic [`RAM_AW-1:0]     addr_q;

  // Pending RAM write
  logic                   buf_valid;
  logic [`RAM_AW-1:0]     buf_addr;
  logic [3:0]             buf_be;
  logic [`AHB_DW-1:0]     buf_data;
  logic [`AHB_DW-1:0]     ram_merged;

  //////////////////////////////////////////////////////////////////////
  // Address phase
  //////////////////////////////////////////////////////////////////////

  assign htrans = htrans_t'(htrans_i);

  // Single master, so HREADY is our own hreadyout
  assign addr_phase = hsel_i && (htrans == NONSEQ || htrans == SEQ) && hreadyout_o;

  // Byte lanes from size and low address bits
  always_comb begin
    case (hsize_t'(hsize_i))
      BYTE:    be_a = 4'b0001 << haddr_i[1:0];
      HALF:    be_a = 4'b0011 << {haddr_i[1], 1'b0};
      default: be_a = 4'b1111;
    endcase
  end

  // RAM reads issue in the address phase
  assign rd_ram = addr_phase && allowed_i && (tgt_i == TGT_RAM) && !hwrite_i;

  //////////////////////////////////////////////////////////////////////
  // Data phase FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (state)
      ST_WAIT: hreadyout_o = uart_ready_i;
      ST_ERR1: hreadyout_o = 1'b0;
      default: hreadyout_o = 1'b1;
    endcase
  end

  // ERROR for both error cycles
  assign hresp_o = (state == ST_ERR1) || (state == ST_ERR2);

  always_comb begin
    state_nxt = state;
    if (hreadyout_o) begin
      if (!addr_phase) begin
        state_nxt = ST_IDLE;
      end else if (!allowed_i) begin
        state_nxt = ST_ERR1;
      end else if (tgt_i == TGT_UART) begin
        state_nxt = ST_WAIT;
      end else begin
        state_nxt = ST_DATA;
      end
    end else if (state == ST_ERR1) begin
      state_nxt = ST_ERR2;
    end
  end

  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      state     <= ST_IDLE;
      tgt_q     <= TGT_NONE;
      write_q   <= 1'b0;
      buf_valid <= 1'b0;
    end else begin
      state <= state_nxt;
      if (addr_phase) begin
        tgt_q   <= tgt_i;
        write_q <= hwrite_i;
      end
      // Write blocked by a read goes to the buffer
      if (wr_dphase && rd_ram) begin
        buf_valid <= 1'b1;
      end else if (buf_commit) begin
        buf_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge HCLK) begin
    if (addr_phase) begin
      addr_q <= haddr_i[`RAM_AW+1:2];
      be_q   <= be_a;
    end
    if (wr_dphase && rd_ram) begin
      buf_addr <= addr_q;
      buf_be   <= be_q;
      buf_data <= hwdata_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // RAM port
  //////////////////////////////////////////////////////////////////////

  assign wr_dphase  = (state == ST_DATA) && write_q && (tgt_q == TGT_RAM);
  // Buffer never holds data during a write data phase
  assign buf_commit = buf_valid && !rd_ram;

  assign ram_re_o    = rd_ram;
  assign ram_we_o    = (wr_dphase && !rd_ram) || buf_commit;
  assign ram_addr_o  = rd_ram ? haddr_i[`RAM_AW+1:2] : (buf_valid ? buf_addr : addr_q);
  assign ram_be_o    = buf_valid ? buf_be : be_q;
  assign ram_wdata_o = buf_valid ? buf_data : hwdata_i;

  // Forward pending bytes over stale RAM data
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      if (buf_valid && (buf_addr == addr_q) && buf_be[b]) begin
        ram_merged[8*b +: 8] = buf_data[8*b +: 8];
      end else begin
        ram_merged[8*b +: 8] = ram_rdata_i[8*b +: 8];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // MMIO port and read mux
  //////////////////////////////////////////////////////////////////////

  // Tohost in a plain data phase, UART once a credit is there
  assign mmio_we_o = ((state == ST_DATA) && write_q && (tgt_q == TGT_TOHOST)) ||
                     ((state == ST_WAIT) && uart_ready_i);
  assign mmio_sel_o   = tgt_q;
  assign mmio_wdata_o = hwdata_i;

  always_comb begin
    case (tgt_q)
      TGT_RAM:    hrdata_o = ram_merged;
      TGT_TOHOST: hrdata_o = mmio_rdata_i;
      default:    hrdata_o = '0;
    endcase
  end

endmodule

/* hdl/ahb_mmio_top.sv */
// AHB-Lite MMIO subsystem top level
// Bus controller with PMA check in front of the RAM and the host
// registers (tohost, UART transmit with credit flow control)

`timescale 1ns/10ps

`include "ahb_mmio_params.svh"

module ahb_mmio_top import ahb_mmio_pkg::*; (
  input  logic                 HCLK,
  input  logic                 reset_i,
  // AHB-Lite slave
  input  logic                 hsel_i,
  input  logic [`AHB_AW-1:0]   haddr_i,
  input  logic [1:0]           htrans_i,
  input  logic                 hwrite_i,
  input  logic [2:0]           hsize_i,
  input  logic [`AHB_DW-1:0]   hwdata_i,
  output logic [`AHB_DW-1:0]   hrdata_o,
  output logic                 hreadyout_o,
  output logic                 hresp_o,
  // Host side
  output logic [`AHB_DW-1:0]   tohost_o,
  output logic [7:0]           uart_data_o,
  output logic                 uart_valid_o,
  input  logic                 uart_credit_i
);

  // PMA result
  target_t              tgt;
  logic                 allowed;

  // RAM port
  logic                 ram_we;
  logic                 ram_re;
  logic [3:0]           ram_be;
  logic [`RAM_AW-1:0]   ram_addr;
  logic [`AHB_DW-1:0]   ram_wdata;
  logic [`AHB_DW-1:0]   ram_rdata;

  // MMIO port
  logic                 mmio_we;
  target_t              mmio_sel;
  logic [`AHB_DW-1:0]   mmio_wdata;
  logic [`AHB_DW-1:0]   mmio_rdata;
  logic                 uart_ready;

  pma_checker u_pma (
    .haddr_i   ( haddr_i  ),
    .hsize_i   ( hsize_i  ),
    .hwrite_i  ( hwrite_i ),
    .tgt_o     ( tgt      ),
    .allowed_o ( allowed  )
  );

  ahb_slave_ctrl u_ctrl (
    .HCLK         ( HCLK        ),
    .reset_i      ( reset_i     ),
    .hsel_i       ( hsel_i      ),
    .htrans_i     ( htrans_i    ),
    .hwrite_i     ( hwrite_i    ),
    .hsize_i      ( hsize_i     ),
    .haddr_i      ( haddr_i     ),
    .hwdata_i     ( hwdata_i    ),
    .tgt_i        ( tgt         ),
    .allowed_i    ( allowed     ),
    .uart_ready_i ( uart_ready  ),
    .ram_rdata_i  ( ram_rdata   ),
    .mmio_rdata_i ( mmio_rdata  ),
    .hrdata_o     ( hrdata_o    ),
    .hreadyout_o  ( hreadyout_o ),
    .hresp_o      ( hresp_o     ),
    .ram_we_o     ( ram_we      ),
    .ram_re_o     ( ram_re      ),
    .ram_be_o     ( ram_be      ),
    .ram_addr_o   ( ram_addr    ),
    .ram_wdata_o  ( ram_wdata   ),
    .mmio_we_o    ( mmio_we     ),
    .mmio_sel_o   ( mmio_sel    ),
    .mmio_wdata_o ( mmio_wdata  )
  );

  ahb_sram u_sram (
    .HCLK    ( HCLK      ),
    .we_i    ( ram_we    ),
    .re_i    ( ram_re    ),
    .be_i    ( ram_be    ),
    .addr_i  ( ram_addr  ),
    .wdata_i ( ram_wdata ),
    .rdata_o ( ram_rdata )
  );

  host_mmio u_host (
    .HCLK          ( HCLK          ),
    .reset_i       ( reset_i       ),
    .we_i          ( mmio_we       ),
    .sel_i         ( mmio_sel      ),
    .wdata_i       ( mmio_wdata    ),
    .uart_credit_i ( uart_credit_i ),
    .rdata_o       ( mmio_rdata    ),
    .tohost_o      ( tohost_o      ),
    .uart_ready_o  ( uart_ready    ),
    .uart_data_o   ( uart_data_o   ),
    .uart_valid_o  ( uart_valid_o  )
  );

endmodule

/* test/tb_clock_gen.sv */
// Testbench clock and reset source
// Free-running HCLK and a synchronous reset held for a fixed number
// of rising edges, released just after an edge

`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release 1 ns after the last reset edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    reset_o = 1'b0;
  end

endmodule

/* test/ahb_mmio_assertions.sv */
// Protocol assertions for the AHB-Lite slave controller
// Two-cycle ERROR response, UART credits spent only by a send, and
// HREADYOUT high while in reset

`timescale 1ns/10ps

module ahb_mmio_assertions import ahb_mmio_pkg::*; (
  input  logic    HCLK,
  input  logic    reset_i,
  input  logic    hreadyout_i,
  input  logic    hresp_i,
  input  logic    mmio_we_i,
  input  target_t mmio_sel_i,
  input  logic    uart_ready_i
);

  // Count of failed assertions
  int   fail_count = 0;
  logic uart_strobe;

  assign uart_strobe = mmio_we_i && (mmio_sel_i == TGT_UART);

  // First ERROR cycle must lead into the second
  err_two_cycle: assert property (@(posedge HCLK) disable iff (reset_i)
    (hresp_i && !hreadyout_i) |=> (hresp_i && hreadyout_i))
    else begin
      fail_count++;
      $error("ERROR response not completed with HREADYOUT high");
    end

  // Credit flag falls only right after a UART strobe
  credit_spent_by_send: assert property (@(posedge HCLK) disable iff (reset_i)
    (uart_ready_i && !uart_strobe) |=> uart_ready_i)
    else begin
      fail_count++;
      $error("UART credits lost without a byte being sent");
    end

  ready_in_reset: assert property (@(posedge HCLK) reset_i |-> hreadyout_i)
    else begin
      fail_count++;
      $error("HREADYOUT low during reset");
    end

endmodule

bind ahb_slave_ctrl ahb_mmio_assertions u_assertions (
  .HCLK         ( HCLK         ),
  .reset_i      ( reset_i      ),
  .hreadyout_i  ( hreadyout_o  ),
  .hresp_i      ( hresp_o      ),
  .mmio_we_i    ( mmio_we_o    ),
  .mmio_sel_i   ( mmio_sel_o   ),
  .uart_ready_i ( uart_ready_i )
);

/* test/ahb_mmio_tb.sv */
// Testbench for the AHB-Lite MMIO subsystem
// Runs pipelined single transfers from the case file, models a UART
// consumer that returns credits after a pseudo-random delay, and checks
// responses, read data, tohost and the received byte stream

`timescale 1ns/10ps

`include "ahb_mmio_params.svh"

module ahb_mmio_tb import ahb_mmio_pkg::*; ();

  localparam int          NUM_CASES        = 20;
  localparam int          FIELDS           = 6;
  localparam int          MAX_CREDIT_DELAY = 8;
  localparam int          WATCHDOG_CYCLES  = NUM_CASES * (MAX_CREDIT_DELAY + 10);
  localparam logic [15:0] LFSR_SEED        = 16'd48;
  localparam logic [15:0] LFSR_TAPS        = 16'hB400;
  localparam logic [31:0] TOHOST_ADDR      = `TOHOST_BASE;
  localparam logic [31:0] UART_ADDR        = `UART_TX_ADDR;
  localparam string       CASE_FILE        = "test/ahb_mmio_cases.txt";

  // One transfer of the case file
  typedef struct packed {
    logic [7:0]  name_idx;
    logic        is_write;
    logic [31:0] addr;
    logic [2:0]  hsize;
    logic [31:0] data;
    logic        is_err;
  } xfer_rec_t;

  logic        HCLK;
  logic        reset_i;
  logic        hsel_i;
  logic [31:0] haddr_i;
  logic [1:0]  htrans_i;
  logic        hwrite_i;
  logic [2:0]  hsize_i;
  logic [31:0] hwdata_i;
  logic [31:0] hrdata_o;
  logic        hreadyout_o;
  logic        hresp_o;
  logic [31:0] tohost_o;
  logic [7:0]  uart_data_o;
  logic        uart_valid_o;
  logic        uart_credit_i;

  logic [31:0] case_mem [NUM_CASES*FIELDS];
  xfer_rec_t   cases [NUM_CASES];
  int          errors;
  int          failed_cases;
  int          last_done;
  int          uart_writes;
  logic [31:0] tohost_model;
  // UART consumer state
  logic [7:0]  exp_bytes [$];
  logic [7:0]  rx_bytes [$];
  int          due_q [$];
  int          cycle_cnt;
  int          sent_cnt;
  int          returned_cnt;
  logic [15:0] lfsr;

  tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(16)) u_clk (
    .clk_o   ( HCLK    ),
    .reset_o ( reset_i )
  );

  ahb_mmio_top DUT (
    .HCLK          ( HCLK          ),
    .reset_i       ( reset_i       ),
    .hsel_i        ( hsel_i        ),
    .haddr_i       ( haddr_i       ),
    .htrans_i      ( htrans_i      ),
    .hwrite_i      ( hwrite_i      ),
    .hsize_i       ( hsize_i       ),
    .hwdata_i      ( hwdata_i      ),
    .hrdata_o      ( hrdata_o      ),
    .hreadyout_o   ( hreadyout_o   ),
    .hresp_o       ( hresp_o       ),
    .tohost_o      ( tohost_o      ),
    .uart_data_o   ( uart_data_o   ),
    .uart_valid_o  ( uart_valid_o  ),
    .uart_credit_i ( uart_credit_i )
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic string case_label(input int idx);
    string name;
    case (cases[idx].name_idx)
      8'd1:    name = "tohost_reset";
      8'd2:    name = "ram_word_wr";
      8'd3:    name = "ram_half_wr";
      8'd4:    name = "ram_byte_wr";
      8'd5:    name = "ram_rd";
      8'd6:    name = "tohost";
      8'd7:    name = "uart_tx";
      8'd8:    name = "misaligned";
      8'd9:    name = "unmapped";
      8'd10:   name = "uart_rd";
      default: name = "unknown";
    endcase
    return $sformatf("%s[%0d]", name, idx);
  endfunction

  // 16-byte tohost block and single UART word
  function automatic bit hits_tohost(input logic [31:0] a);
    return a[31:4] == TOHOST_ADDR[31:4];
  endfunction

  function automatic bit hits_uart(input logic [31:0] a);
    return a[31:2] == UART_ADDR[31:2];
  endfunction

  // Galois step, bit taken is the old lsb
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? LFSR_TAPS : 16'h0000);
  endfunction

  // 1 to MAX_CREDIT_DELAY cycles from three LFSR bits
  task automatic draw_delay(output int delay);
    logic [2:0] bits;
    for (int b = 0; b < 3; b++) begin
      bits[b] = lfsr[0];
      lfsr    = lfsr_next(lfsr);
    end
    delay = 1 + int'(bits);
  endtask

  task automatic load_cases;
    $readmemh(CASE_FILE, case_mem);
    for (int i = 0; i < NUM_CASES; i++) begin
      cases[i].name_idx = case_mem[FIELDS*i][7:0];
      cases[i].is_write = case_mem[FIELDS*i+1][0];
      cases[i].addr     = case_mem[FIELDS*i+2];
      cases[i].hsize    = case_mem[FIELDS*i+3][2:0];
      cases[i].data     = case_mem[FIELDS*i+4];
      cases[i].is_err   = case_mem[FIELDS*i+5][0];
    end
    // Short file leaves the last record empty
    if ($isunknown(cases[NUM_CASES-1].name_idx) || cases[NUM_CASES-1].name_idx == 8'd0) begin
      $display("Case file %s holds fewer than %0d records", CASE_FILE, NUM_CASES);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus master
  //////////////////////////////////////////////////////////////////////

  task automatic drive_addr(input int idx);
    hsel_i   = 1'b1;
    htrans_i = NONSEQ;
    haddr_i  = cases[idx].addr;
    hwrite_i = cases[idx].is_write;
    hsize_i  = cases[idx].hsize;
  endtask

  task automatic drive_idle;
    hsel_i   = 1'b0;
    htrans_i = IDLE;
    haddr_i  = '0;
    hwrite_i = 1'b0;
    hsize_i  = '0;
  endtask

  // Tohost follows every completed OKAY write to it
  task automatic check_tohost;
    string name;
    name = (last_done < 0) ? "after_reset" : case_label(last_done);
    assert (tohost_o == tohost_model) else begin
      $display("MISMATCH %s: tohost_o expected %h actual %h", name, tohost_model, tohost_o);
      errors++;
    end
  endtask

  // Checks at the sample point of the completing data phase cycle
  task automatic finish_case(input int idx, input int waits);
    int    errs_before;
    string name;
    errs_before = errors;
    name        = case_label(idx);
    assert (hresp_o == cases[idx].is_err) else begin
      $display("MISMATCH %s: hresp expected %0d actual %0d", name, cases[idx].is_err, hresp_o);
      errors++;
    end
    if (cases[idx].is_err) begin
      assert (waits == 1) else begin
        $display("%s: ERROR response took %0d low cycles instead of one", name, waits);
        errors++;
      end
    end else if (cases[idx].is_write && hits_uart(cases[idx].addr)) begin
      exp_bytes.push_back(cases[idx].data[7:0]);
      // Initial credits cover the first sends
      if (uart_writes < `UART_CREDITS) begin
        assert (waits == 0) else begin
          $display("%s: UART write stalled %0d cycles with initial credits left", name, waits);
          errors++;
        end
      end
      uart_writes++;
    end else begin
      assert (waits == 0) else begin
        $display("%s: %0d unexpected wait states", name, waits);
        errors++;
      end
      if (cases[idx].is_write && hits_tohost(cases[idx].addr)) begin
        tohost_model = cases[idx].data;
      end
      if (!cases[idx].is_write) begin
        assert (hrdata_o == cases[idx].data) else begin
          $display("MISMATCH %s: hrdata expected %h actual %h", name, cases[idx].data, hrdata_o);
          errors++;
        end
      end
    end
    if (errors != errs_before) begin
      failed_cases++;
    end
    last_done = idx;
    $display("case %0d %s %s", idx, name, (errors == errs_before) ? "ok" : "failed");
  endtask

  // Address phase of case i overlaps the data phase of case i-1
  task automatic run_cases;
    int prev;
    int waits;
    prev = -1;
    for (int i = 0; i <= NUM_CASES; i++) begin
      @(posedge HCLK);
      #1;
      check_tohost();
      if (i < NUM_CASES) begin
        drive_addr(i);
      end else begin
        drive_idle();
      end
      hwdata_i = (prev >= 0 && cases[prev].is_write) ? cases[prev].data : '0;
      waits = 0;
      @(negedge HCLK);
      while (!hreadyout_o) begin
        waits++;
        @(negedge HCLK);
      end
      if (prev >= 0) begin
        finish_case(prev, waits);
      end
      prev = (i < NUM_CASES) ? i : -1;
    end
    @(posedge HCLK);
    #1;
    check_tohost();
  endtask

  task automatic check_uart_stream;
    assert (rx_bytes.size() == exp_bytes.size()) else begin
      $display("MISMATCH uart_stream: byte count expected %0d actual %0d",
               exp_bytes.size(), rx_bytes.size());
      errors++;
    end
    for (int k = 0; k < exp_bytes.size() && k < rx_bytes.size(); k++) begin
      assert (rx_bytes[k] == exp_bytes[k]) else begin
        $display("MISMATCH uart_byte[%0d]: expected %h actual %h", k, exp_bytes[k], rx_bytes[k]);
        errors++;
      end
    end
  endtask

  // Failures of the bound protocol assertions
  task automatic check_assertions;
    int fails;
    fails = DUT.u_ctrl.u_assertions.fail_count;
    assert (fails == 0) else begin
      $display("Bound protocol assertions failed %0d times", fails);
      errors += fails;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // UART consumer
  //////////////////////////////////////////////////////////////////////

  task automatic accept_byte;
    int delay;
    assert (sent_cnt - returned_cnt < `UART_CREDITS) else begin
      $display("uart_valid_o high with all %0d credits outstanding", sent_cnt - returned_cnt);
      errors++;
    end
    sent_cnt++;
    rx_bytes.push_back(uart_data_o);
    draw_delay(delay);
    due_q.push_back(cycle_cnt + delay);
  endtask

  always @(negedge HCLK) begin
    if (!reset_i && uart_valid_o) begin
      accept_byte();
    end
  end

  // Credits go back in send order, one pulse per cycle at most
  initial begin
    uart_credit_i = 1'b0;
    cycle_cnt     = 0;
    sent_cnt      = 0;
    returned_cnt  = 0;
    lfsr          = LFSR_SEED;
    forever begin
      @(posedge HCLK);
      #1;
      cycle_cnt++;
      if (uart_credit_i) begin
        returned_cnt++;
        uart_credit_i = 1'b0;
      end
      if (due_q.size() > 0 && due_q[0] <= cycle_cnt) begin
        void'(due_q.pop_front());
        uart_credit_i = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    drive_idle();
    hwdata_i     = '0;
    errors       = 0;
    failed_cases = 0;
    last_done    = -1;
    uart_writes  = 0;
    tohost_model = '0;
    load_cases();
    @(negedge reset_i);
    run_cases();
    check_uart_stream();
    check_assertions();
    $display("cases run %0d, cases failed %0d, errors %0d", NUM_CASES, failed_cases, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    @(negedge reset_i);
    repeat (WATCHDOG_CYCLES) @(posedge HCLK);
    $display("Watchdog expired after %0d cycles, transfers did not complete", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* ahb_mmio_sys.f */
+incdir+hdl
hdl/ahb_mmio_pkg.sv
hdl/pma_checker.sv
hdl/ahb_sram.sv
hdl/host_mmio.sv
hdl/ahb_slave_ctrl.sv
hdl/ahb_mmio_top.sv
test/tb_clock_gen.sv
test/ahb_mmio_assertions.sv
test/ahb_mmio_tb.sv

/* Makefile */
# Verilator build and run for the AHB-Lite MMIO subsystem
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= ahb_mmio_tb
FILELIST  ?= ahb_mmio_sys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= STATUS: PASS

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output is shown and searched in memory, the simulation runs from the project root
run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* test/ahb_mmio_cases.txt */
// name op addr size data resp: op 1 write, size 0 byte 1 half 2 word, resp 1 ERROR
// data is the write data, or the expected read data of an OKAY read
01 0 80001000 2 00000000 0
02 1 80000010 2 11223344 0
03 1 80000012 1 aabb0000 0
04 1 80000011 0 0000cc00 0
05 0 80000010 2 aabbcc44 0
06 1 80001000 2 cafe0001 0
06 0 80001004 2 cafe0001 0
07 1 80001080 2 00000041 0
07 1 80001080 2 00000042 0
07 1 80001080 0 00000043 0
07 1 80001080 2 00000044 0
07 1 80001080 2 12345645 0
07 1 80001080 2 00000046 0
08 1 80000012 2 deadbeef 1
08 0 80000001 1 00000000 1
09 1 90000000 2 deadbeef 1
09 1 80001010 2 deadbeef 1
0a 0 80001080 2 00000000 1
05 0 80000010 2 aabbcc44 0
06 0 80001000 2 cafe0001 0
